//--- Makefile
VERILATOR := verilator
TOP       := dualIssueTb
FILELIST  := tb.f
OBJDIR    := obj_dir
FLAGS     := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall -Wno-fatal
SIMARGS   := +verilator+error+limit+1000
PASSMSG   := ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASSMSG)'

clean:
	rm -rf $(OBJDIR)

//--- hw/alu.sv
module alu (
    input  coreCfgPkg::dataWord operandA,
    input  coreCfgPkg::dataWord operandB,
    input  coreCfgPkg::aluOp    op,
    output coreCfgPkg::dataWord result
);

    logic [4:0] shamt;

    assign shamt = operandB[4:0]; // rv32 shifts use the low five bits

    always_comb begin
        case (op)
            coreCfgPkg::opAdd:   result = operandA + operandB;
            coreCfgPkg::opSub:   result = operandA - operandB;
            coreCfgPkg::opSll:   result = operandA << shamt;
            coreCfgPkg::opSlt:   result = {31'b0, $signed(operandA) < $signed(operandB)};
            coreCfgPkg::opSltu:  result = {31'b0, operandA < operandB};
            coreCfgPkg::opXor:   result = operandA ^ operandB;
            coreCfgPkg::opSrl:   result = operandA >> shamt;
            coreCfgPkg::opSra:   result = $unsigned($signed(operandA) >>> shamt);
            coreCfgPkg::opOr:    result = operandA | operandB;
            coreCfgPkg::opAnd:   result = operandA & operandB;
            coreCfgPkg::opPassB: result = operandB;
            default:             result = operandA + operandB;
        endcase
    end

endmodule

//--- hw/bypassUnit.sv
module bypassUnit (
    input  rvIsaPkg::regIdx      dxSrcA1,
    input  rvIsaPkg::regIdx      dxSrcA2,
    input  rvIsaPkg::regIdx      dxSrcB1,
    input  rvIsaPkg::regIdx      dxSrcB2,
    input  rvIsaPkg::regIdx      xmDestA,
    input  rvIsaPkg::regIdx      xmDestB,
    input  logic                 xmWriteEnA,
    input  logic                 xmWriteEnB,
    input  rvIsaPkg::regIdx      mwDestA,
    input  rvIsaPkg::regIdx      mwDestB,
    input  logic                 mwWriteEnA,
    input  logic                 mwWriteEnB,
    output coreCfgPkg::bypassSel selA1,
    output coreCfgPkg::bypassSel selA2,
    output coreCfgPkg::bypassSel selB1,
    output coreCfgPkg::bypassSel selB2
);

    function automatic coreCfgPkg::bypassSel pickSource(input rvIsaPkg::regIdx src);
        coreCfgPkg::bypassSel sel;
        sel = coreCfgPkg::selRegFile;
        if (src != '0) begin // x0 never forwards
            if (xmWriteEnA && xmDestA == src)
                sel = coreCfgPkg::selAXm;
            else if (xmWriteEnB && xmDestB == src)
                sel = coreCfgPkg::selBXm;
            else if (mwWriteEnA && mwDestA == src)
                sel = coreCfgPkg::selAMw;
            else if (mwWriteEnB && mwDestB == src)
                sel = coreCfgPkg::selBMw;
        end
        return sel;
    endfunction

    always_comb begin
        selA1 = pickSource(dxSrcA1);
        selA2 = pickSource(dxSrcA2);
        selB1 = pickSource(dxSrcB1);
        selB2 = pickSource(dxSrcB2);
    end

endmodule

//--- hw/coreCfgPkg.sv
package coreCfgPkg;

    typedef logic [31:0] dataWord;

    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opSll,
        opSlt,
        opSltu,
        opXor,
        opSrl,
        opSra,
        opOr,
        opAnd,
        opPassB    // lui, immediate straight through
    } aluOp;

    // operand source, youngest producer wins
    typedef enum logic [2:0] {
        selRegFile,
        selAXm,
        selBXm,
        selAMw,
        selBMw
    } bypassSel;

    localparam int counterWidth = 32;

endpackage

//--- hw/decodeUnit.sv
module decodeUnit (
    input  rvIsaPkg::instWord   packetA,
    input  rvIsaPkg::instWord   packetB,
    input  logic                packetValid,
    output rvIsaPkg::regIdx     readIdxA1,
    output rvIsaPkg::regIdx     readIdxA2,
    output rvIsaPkg::regIdx     readIdxB1,
    output rvIsaPkg::regIdx     readIdxB2,
    output rvIsaPkg::regIdx     destA,
    output rvIsaPkg::regIdx     destB,
    output logic                writeEnA,
    output logic                writeEnB,
    output coreCfgPkg::aluOp    opA,
    output coreCfgPkg::aluOp    opB,
    output logic                useImmA,
    output logic                useImmB,
    output coreCfgPkg::dataWord immA,
    output coreCfgPkg::dataWord immB,
    output logic                splitPacket,
    output logic                haltSeen
);

    rvIsaPkg::instWord slot [2];
    logic [1:0] isOp, isOpImm, isLui, isHalt;
    logic [1:0] live, writeEn;
    rvIsaPkg::regIdx src1 [2];
    rvIsaPkg::regIdx src2 [2];
    rvIsaPkg::regIdx dest [2];
    coreCfgPkg::aluOp aluSel [2];
    coreCfgPkg::dataWord imm [2];

    function automatic coreCfgPkg::aluOp aluFor(input rvIsaPkg::instWord w);
        coreCfgPkg::aluOp sel;
        logic alt;
        // funct7[5] picks sub/sra, for op-imm only on the shift
        alt = w.rFmt.funct7[5] && (w.rFmt.opcode == rvIsaPkg::op || w.rFmt.funct3 == 3'b101);
        case (w.rFmt.funct3)
            3'b000:  sel = alt ? coreCfgPkg::opSub : coreCfgPkg::opAdd;
            3'b001:  sel = coreCfgPkg::opSll;
            3'b010:  sel = coreCfgPkg::opSlt;
            3'b011:  sel = coreCfgPkg::opSltu;
            3'b100:  sel = coreCfgPkg::opXor;
            3'b101:  sel = alt ? coreCfgPkg::opSra : coreCfgPkg::opSrl;
            3'b110:  sel = coreCfgPkg::opOr;
            default: sel = coreCfgPkg::opAnd;
        endcase
        if (w.uFmt.opcode == rvIsaPkg::lui)
            sel = coreCfgPkg::opPassB;
        return sel;
    endfunction

    assign slot[0] = packetA;
    assign slot[1] = packetB;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            isOp[s]    = slot[s].rFmt.opcode == rvIsaPkg::op;
            isOpImm[s] = slot[s].iFmt.opcode == rvIsaPkg::opImm;
            isLui[s]   = slot[s].uFmt.opcode == rvIsaPkg::lui;
            isHalt[s]  = slot[s].rFmt.opcode == rvIsaPkg::halt;
            aluSel[s]  = aluFor(slot[s]);
            if (isLui[s])
                imm[s] = {slot[s].uFmt.imm, 12'h000};
            else
                imm[s] = {{20{slot[s].iFmt.imm[11]}}, slot[s].iFmt.imm};
        end
    end

    // halt in A squashes B
    assign live = {packetValid && !isHalt[0], packetValid};

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            writeEn[s] = live[s] && (isOp[s] || isOpImm[s] || isLui[s])
                         && slot[s].rFmt.rd != '0;
            dest[s] = writeEn[s] ? slot[s].rFmt.rd : '0;
            src1[s] = (live[s] && (isOp[s] || isOpImm[s])) ? slot[s].rFmt.rs1 : '0;
            src2[s] = (live[s] && isOp[s]) ? slot[s].rFmt.rs2 : '0;
        end
    end

    assign readIdxA1 = src1[0];
    assign readIdxA2 = src2[0];
    assign readIdxB1 = src1[1];
    assign readIdxB2 = src2[1];
    assign destA     = dest[0];
    assign destB     = dest[1];
    assign writeEnA  = writeEn[0];
    assign writeEnB  = writeEn[1];
    assign opA       = aluSel[0];
    assign opB       = aluSel[1];
    assign useImmA   = isOpImm[0] || isLui[0];
    assign useImmB   = isOpImm[1] || isLui[1];
    assign immA      = imm[0];
    assign immB      = imm[1];

    // B depends on A, or both write the same register
    assign splitPacket = writeEn[0] &&
                         (dest[0] == src1[1] || dest[0] == src2[1] || dest[0] == dest[1]);
    assign haltSeen    = |(live & isHalt);

endmodule

//--- hw/dualIssueCore.sv
module dualIssueCore #(
    parameter coreCfgPkg::dataWord resetPc = 32'h0000_0000
) (
    input  logic                                clock,
    input  logic                                reset,
    input  rvIsaPkg::instWord                   instA,
    input  rvIsaPkg::instWord                   instB,
    output coreCfgPkg::dataWord                 instAddr,
    output logic                                retireValidA,
    output logic                                retireValidB,
    output rvIsaPkg::regIdx                     retireRegA,
    output rvIsaPkg::regIdx                     retireRegB,
    output coreCfgPkg::dataWord                 retireDataA,
    output coreCfgPkg::dataWord                 retireDataB,
    output logic                                halted,
    output logic [coreCfgPkg::counterWidth-1:0] cycleCount
);

    rvIsaPkg::instWord packetA, packetB;
    logic packetValid, splitPacket, haltSeen;
    rvIsaPkg::regIdx readIdxA1, readIdxA2, readIdxB1, readIdxB2, destA, destB;
    logic writeEnA, writeEnB, useImmA, useImmB;
    coreCfgPkg::aluOp opA, opB;
    coreCfgPkg::dataWord immA, immB, rfDataA1, rfDataA2, rfDataB1, rfDataB2;

    logic dxWriteEnA, dxWriteEnB, dxHalt, dxUseImmA, dxUseImmB;
    rvIsaPkg::regIdx dxDestA, dxDestB, dxSrcA1, dxSrcA2, dxSrcB1, dxSrcB2;
    coreCfgPkg::aluOp dxOpA, dxOpB;
    coreCfgPkg::dataWord dxImmA, dxImmB, dxDataA1, dxDataA2, dxDataB1, dxDataB2;

    logic xmWriteEnA, xmWriteEnB, xmHalt;
    logic mwWriteEnA, mwWriteEnB, mwHalt;
    rvIsaPkg::regIdx xmDestA, xmDestB, mwDestA, mwDestB;
    coreCfgPkg::dataWord xmResultA, xmResultB, mwResultA, mwResultB;

    coreCfgPkg::bypassSel selA1, selA2, selB1, selB2;
    coreCfgPkg::dataWord operandA1, operandA2, operandB1, operandB2, resultA, resultB;
    logic [coreCfgPkg::counterWidth-1:0] counter;

    // ------------------------------------------------------------------------
    // fetch and decode

    fetchUnit #(.resetPc(resetPc)) fetch (.packetPcA(), .*);

    decodeUnit decode (.*);

    regFile regs (
        .clock,
        .reset,
        .readIdxA1,
        .readIdxA2,
        .readIdxB1,
        .readIdxB2,
        .writeEnA   (mwWriteEnA),
        .writeEnB   (mwWriteEnB),
        .writeRegA  (mwDestA),
        .writeRegB  (mwDestB),
        .writeDataA (mwResultA),
        .writeDataB (mwResultB),
        .readDataA1 (rfDataA1),
        .readDataA2 (rfDataA2),
        .readDataB1 (rfDataB1),
        .readDataB2 (rfDataB2)
    );

    // ------------------------------------------------------------------------
    // execute

    bypassUnit bypass (.*);

    function automatic coreCfgPkg::dataWord pickOperand(
        input coreCfgPkg::bypassSel sel,
        input coreCfgPkg::dataWord  fromRf
    );
        case (sel)
            coreCfgPkg::selAXm: return xmResultA;
            coreCfgPkg::selBXm: return xmResultB;
            coreCfgPkg::selAMw: return mwResultA;
            coreCfgPkg::selBMw: return mwResultB;
            default:            return fromRf;
        endcase
    endfunction

    always_comb begin
        operandA1 = pickOperand(selA1, dxDataA1);
        operandA2 = dxUseImmA ? dxImmA : pickOperand(selA2, dxDataA2); // imm wins
        operandB1 = pickOperand(selB1, dxDataB1);
        operandB2 = dxUseImmB ? dxImmB : pickOperand(selB2, dxDataB2);
    end

    alu aluA (.operandA(operandA1), .operandB(operandA2), .op(dxOpA), .result(resultA));
    alu aluB (.operandA(operandB1), .operandB(operandB2), .op(dxOpB), .result(resultB));

    // ------------------------------------------------------------------------
    // stage registers

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dxWriteEnA <= 1'b0;
            dxWriteEnB <= 1'b0;
            dxHalt     <= 1'b0;
            xmWriteEnA <= 1'b0;
            xmWriteEnB <= 1'b0;
            xmHalt     <= 1'b0;
            mwWriteEnA <= 1'b0;
            mwWriteEnB <= 1'b0;
            mwHalt     <= 1'b0;
        end else begin
            dxWriteEnA <= writeEnA;
            dxWriteEnB <= writeEnB && !splitPacket; // bubble, B reissues next cycle
            dxHalt     <= haltSeen;
            xmWriteEnA <= dxWriteEnA;
            xmWriteEnB <= dxWriteEnB;
            xmHalt     <= dxHalt;
            mwWriteEnA <= xmWriteEnA;
            mwWriteEnB <= xmWriteEnB;
            mwHalt     <= xmHalt;
        end
    end

    always_ff @(posedge clock) begin
        dxDestA   <= destA;
        dxDestB   <= destB;
        dxSrcA1   <= readIdxA1;
        dxSrcA2   <= readIdxA2;
        dxSrcB1   <= readIdxB1;
        dxSrcB2   <= readIdxB2;
        dxOpA     <= opA;
        dxOpB     <= opB;
        dxUseImmA <= useImmA;
        dxUseImmB <= useImmB;
        dxImmA    <= immA;
        dxImmB    <= immB;
        dxDataA1  <= rfDataA1;
        dxDataA2  <= rfDataA2;
        dxDataB1  <= rfDataB1;
        dxDataB2  <= rfDataB2;
        xmDestA   <= dxDestA;
        xmDestB   <= dxDestB;
        xmResultA <= resultA;
        xmResultB <= resultB;
        mwDestA   <= xmDestA;
        mwDestB   <= xmDestB;
        mwResultA <= xmResultA;
        mwResultB <= xmResultB;
    end

    assign retireValidA = mwWriteEnA;
    assign retireValidB = mwWriteEnB;
    assign retireRegA   = mwDestA;
    assign retireRegB   = mwDestB;
    assign retireDataA  = mwResultA;
    assign retireDataB  = mwResultB;

    // cycle counter, sampled once when the halt reaches writeback
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            counter    <= '0;
            cycleCount <= '0;
            halted     <= 1'b0;
        end else begin
            counter <= counter + 1'b1;
            if (mwHalt && !halted) begin
                cycleCount <= counter;
                halted     <= 1'b1;
            end
        end
    end

endmodule

//--- hw/fetchUnit.sv
module fetchUnit #(
    parameter coreCfgPkg::dataWord resetPc = 32'h0000_0000
) (
    input  logic                clock,
    input  logic                reset,
    input  rvIsaPkg::instWord   instA,
    input  rvIsaPkg::instWord   instB,
    input  logic                splitPacket,
    input  logic                haltSeen,
    output coreCfgPkg::dataWord instAddr,
    output rvIsaPkg::instWord   packetA,
    output rvIsaPkg::instWord   packetB,
    output coreCfgPkg::dataWord packetPcA,
    output logic                packetValid
);

    coreCfgPkg::dataWord pc;
    logic frozen;   // set once a halt has been decoded
    logic advance;

    assign advance  = !frozen && !haltSeen && !splitPacket;
    assign instAddr = pc;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc          <= resetPc;
            frozen      <= 1'b0;
            packetValid <= 1'b0;
            packetA     <= rvIsaPkg::nopWord;
            packetB     <= rvIsaPkg::nopWord;
        end else if (frozen || haltSeen) begin
            // nothing younger than the halt gets in
            frozen      <= 1'b1;
            packetValid <= 1'b0;
            packetA     <= rvIsaPkg::nopWord;
            packetB     <= rvIsaPkg::nopWord;
        end else if (splitPacket) begin
            packetA <= rvIsaPkg::nopWord; // A already issued, B goes alone
        end else begin
            pc          <= pc + 32'd8;
            packetValid <= 1'b1;
            packetA     <= instA;
            packetB     <= instB;
        end
    end

    always_ff @(posedge clock) begin
        if (advance)
            packetPcA <= pc;
    end

endmodule

//--- hw/regFile.sv
module regFile (
    input  logic                clock,
    input  logic                reset,
    input  rvIsaPkg::regIdx     readIdxA1,
    input  rvIsaPkg::regIdx     readIdxA2,
    input  rvIsaPkg::regIdx     readIdxB1,
    input  rvIsaPkg::regIdx     readIdxB2,
    input  logic                writeEnA,
    input  logic                writeEnB,
    input  rvIsaPkg::regIdx     writeRegA,
    input  rvIsaPkg::regIdx     writeRegB,
    input  coreCfgPkg::dataWord writeDataA,
    input  coreCfgPkg::dataWord writeDataB,
    output coreCfgPkg::dataWord readDataA1,
    output coreCfgPkg::dataWord readDataA2,
    output coreCfgPkg::dataWord readDataB1,
    output coreCfgPkg::dataWord readDataB2
);

    coreCfgPkg::dataWord bank [32];

    // write-through, B is younger so it wins
    function automatic coreCfgPkg::dataWord readPort(input rvIsaPkg::regIdx idx);
        if (idx == '0)
            return '0;
        if (writeEnB && writeRegB == idx)
            return writeDataB;
        if (writeEnA && writeRegA == idx)
            return writeDataA;
        return bank[idx];
    endfunction

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                bank[i] <= '0;
            end
        end else begin
            if (writeEnA && writeRegA != '0)
                bank[writeRegA] <= writeDataA;
            if (writeEnB && writeRegB != '0)
                bank[writeRegB] <= writeDataB;
        end
    end

    always_comb begin
        readDataA1 = readPort(readIdxA1);
        readDataA2 = readPort(readIdxA2);
        readDataB1 = readPort(readIdxB1);
        readDataB2 = readPort(readIdxB2);
    end

endmodule

//--- hw/rvIsaPkg.sv
package rvIsaPkg;

    // major opcodes used by this core
    localparam logic [6:0] opImm = 7'b0010011;
    localparam logic [6:0] op    = 7'b0110011;
    localparam logic [6:0] lui   = 7'b0110111;
    localparam logic [6:0] halt  = 7'b0001011; // custom-0 space

    localparam logic [31:0] nopWord = 32'h0000_0013; // addi x0, x0, 0

    typedef logic [4:0] regIdx;

    typedef struct packed {
        logic [6:0] funct7;
        regIdx      rs2;
        regIdx      rs1;
        logic [2:0] funct3;
        regIdx      rd;
        logic [6:0] opcode;
    } rTypeFields;

    typedef struct packed {
        logic [11:0] imm;
        regIdx       rs1;
        logic [2:0]  funct3;
        regIdx       rd;
        logic [6:0]  opcode;
    } iTypeFields;

    typedef struct packed {
        logic [19:0] imm;
        regIdx       rd;
        logic [6:0]  opcode;
    } uTypeFields;

    // same 32 bits seen through each format
    typedef union packed {
        rTypeFields rFmt;
        iTypeFields iFmt;
        uTypeFields uFmt;
    } instWord;

endpackage

//--- sim/dualIssueCore_properties.sv
module dualIssueCore_properties (
    input logic            clock,
    input logic            reset,
    input logic            retireValidA,
    input logic            retireValidB,
    input rvIsaPkg::regIdx retireRegA,
    input rvIsaPkg::regIdx retireRegB,
    input logic            halted
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned assertFailures = 0; // read by the testbench at the end

    // the intra-packet split keeps the two slots on different registers
    distinctRetireRegs: assert property (@(posedge clock) disable iff (reset)
        retireValidA && retireValidB |-> retireRegA != retireRegB)
        else begin
            $error("both slots retired register x%0d in one cycle", retireRegA);
            assertFailures++;
        end

    haltedSticky: assert property (@(posedge clock) disable iff (reset)
        halted |=> halted)
        else begin
            $error("halted fell without a reset");
            assertFailures++;
        end

    noRetireAfterHalt: assert property (@(posedge clock) disable iff (reset)
        halted |-> !(retireValidA || retireValidB))
        else begin
            $error("an instruction retired after halted was set");
            assertFailures++;
        end

endmodule

//--- sim/dualIssueTb.sv
module dualIssueTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int memWords    = 256;
    localparam int haltLimit   = 400; // cycles allowed from reset to halted
    localparam int drainCycles = 8;
    localparam logic [31:0] haltWord = 32'h0000_000b;
    localparam logic [31:0] bootPc   = 32'h0000_0000;

    logic clock;
    logic reset;
    rvIsaPkg::instWord instA;
    rvIsaPkg::instWord instB;
    coreCfgPkg::dataWord instAddr;
    logic retireValidA;
    logic retireValidB;
    rvIsaPkg::regIdx retireRegA;
    rvIsaPkg::regIdx retireRegB;
    coreCfgPkg::dataWord retireDataA;
    coreCfgPkg::dataWord retireDataB;
    logic halted;
    logic [coreCfgPkg::counterWidth-1:0] cycleCount;

    logic [31:0] imem [memWords];
    logic [31:0] refRegs [32];
    logic [31:0] expReg [$];
    logic [31:0] expData [$];
    logic [31:0] gotReg [$];
    logic [31:0] gotData [$];
    int progLen;
    int dualRetires;
    int errorCount;
    int checkCount;
    logic [31:0] lcgState;

    dualIssueCore #(.resetPc(bootPc)) dualIssueCore_inst (.*);

    bind dualIssueCore dualIssueCore_properties props (
        .clock        (clock),
        .reset        (reset),
        .retireValidA (retireValidA),
        .retireValidB (retireValidB),
        .retireRegA   (retireRegA),
        .retireRegB   (retireRegB),
        .halted       (halted)
    );

    assign instA = imem[instAddr[9:2]];
    assign instB = imem[instAddr[9:2] + 8'd1]; // next word of the packet

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // ------------------------------------------------------------------------
    // encoding, reference model, checking

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return (a >> b[4:0]) | ((alt && a[31]) ? ~(32'hffff_ffff >> b[4:0]) : 0);
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic place(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic clearMemory();
        for (int i = 0; i < memWords; i++)
            imem[i] = iType(i[11:0], 5'd0, 3'b000, 5'd0); // addi x0 tagged with its address
        progLen = 0;
    endtask

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    // sequential execution up to the first halt
    task automatic modelProgram();
        logic [31:0] w;
        logic [31:0] val;
        logic writes;
        for (int r = 0; r < 32; r++)
            refRegs[r] = '0;
        expReg.delete();
        expData.delete();
        for (int idx = 0; idx < memWords; idx++) begin
            w = imem[idx];
            if (w[6:0] == 7'b0001011)
                break;
            writes = 1'b1;
            case (w[6:0])
                7'b0110011: val = aluModel(w[14:12], w[30], refRegs[w[19:15]], refRegs[w[24:20]]);
                7'b0010011: val = aluModel(w[14:12], w[30] && w[14:12] == 3'b101,
                                           refRegs[w[19:15]], {{20{w[31]}}, w[31:20]});
                7'b0110111: val = {w[31:12], 12'h000};
                default:    writes = 1'b0;
            endcase
            if (writes && w[11:7] != 5'd0) begin
                refRegs[w[11:7]] = val;
                expReg.push_back({27'd0, w[11:7]});
                expData.push_back(val);
            end
        end
    endtask

    task automatic sampleRetire();
        if (retireValidA) begin
            gotReg.push_back({27'd0, retireRegA});
            gotData.push_back(retireDataA);
        end
        if (retireValidB) begin
            gotReg.push_back({27'd0, retireRegB});
            gotData.push_back(retireDataB);
        end
        if (retireValidA && retireValidB)
            dualRetires++;
    endtask

    task automatic runProgram(input string name);
        int cycles;
        logic [31:0] heldCount;
        logic [31:0] heldAddr;
        modelProgram();
        gotReg.delete();
        gotData.delete();
        dualRetires = 0;
        @(negedge clock);
        reset = 1'b1;
        repeat (5) @(negedge clock);
        // state held by reset
        compareValue({name, " instAddr at reset"}, instAddr, bootPc);
        compareValue({name, " halted at reset"}, {31'd0, halted}, 32'd0);
        compareValue({name, " cycleCount at reset"}, cycleCount, 32'd0);
        compareValue({name, " retire strobes at reset"},
                     {30'd0, retireValidA, retireValidB}, 32'd0);
        reset = 1'b0;
        cycles = 0;
        while (!halted && cycles < haltLimit) begin
            @(negedge clock);
            sampleRetire();
            cycles++;
        end
        if (!halted) begin
            errorCount++;
            $display("%s: the core did not halt within %0d cycles", name, haltLimit);
        end
        heldCount = cycleCount;
        heldAddr  = instAddr;
        if (heldCount == 0) begin
            errorCount++;
            $display("%s: cycleCount is still zero after the halt", name);
        end
        for (int d = 0; d < drainCycles; d++) begin // core must stay quiet
            @(negedge clock);
            sampleRetire();
            compareValue({name, " halted"}, {31'd0, halted}, 32'd1);
            compareValue({name, " cycleCount"}, cycleCount, heldCount);
            compareValue({name, " instAddr"}, instAddr, heldAddr); // fetch frozen
        end
        compareValue({name, " retire count"}, gotReg.size(), expReg.size());
        for (int i = 0; i < expReg.size() && i < gotReg.size(); i++) begin
            compareValue($sformatf("%s retireReg[%0d]", name, i), gotReg[i], expReg[i]);
            compareValue($sformatf("%s retireData[%0d]", name, i), gotData[i], expData[i]);
        end
        for (int r = 0; r < 32; r++)
            compareValue($sformatf("%s x%0d", name, r), dualIssueCore_inst.regs.bank[r],
                         refRegs[r]);
    endtask

    // ------------------------------------------------------------------------
    // directed tests

    task automatic independentPairs();
        clearMemory();
        place(uType(20'h12345, 5'd1));
        place(iType(12'd100, 5'd0, 3'b000, 5'd2));
        place(iType(12'hff9, 5'd0, 3'b000, 5'd3));
        place(uType(20'hfffff, 5'd4));
        place(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd5));
        place(rType(7'h20, 5'd4, 5'd3, 3'b000, 5'd6));
        place(rType(7'h00, 5'd3, 5'd1, 3'b100, 5'd7));
        place(rType(7'h00, 5'd4, 5'd2, 3'b110, 5'd8));
        place(haltWord);
        runProgram("independentPairs");
        compareValue("independentPairs dualRetires", dualRetires, 32'd4);
    endtask

    task automatic splitPackets();
        clearMemory();
        place(iType(12'd3, 5'd0, 3'b000, 5'd1));
        place(iType(12'd4, 5'd1, 3'b000, 5'd2));   // rs1 on A
        place(iType(12'd1, 5'd2, 3'b000, 5'd3));
        place(rType(7'h00, 5'd3, 5'd1, 3'b000, 5'd4)); // rs2 on A
        place(uType(20'habcde, 5'd5));
        place(iType(12'h123, 5'd5, 3'b000, 5'd5));
        place(iType(12'h055, 5'd0, 3'b110, 5'd6));
        place(iType(12'h00f, 5'd0, 3'b100, 5'd6));  // same rd
        place(haltWord);
        runProgram("splitPackets");
        compareValue("splitPackets dualRetires", dualRetires, 32'd0);
    endtask

    task automatic bypassChains();
        clearMemory();
        place(iType(12'd10, 5'd0, 3'b000, 5'd1));
        place(iType(12'hfec, 5'd0, 3'b000, 5'd2));
        place(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        place(rType(7'h20, 5'd1, 5'd2, 3'b000, 5'd4));
        place(rType(7'h00, 5'd1, 5'd3, 3'b001, 5'd5));
        place(rType(7'h20, 5'd2, 5'd4, 3'b101, 5'd6));
        place(rType(7'h00, 5'd4, 5'd5, 3'b100, 5'd7));
        place(rType(7'h00, 5'd3, 5'd6, 3'b110, 5'd8));
        place(rType(7'h00, 5'd8, 5'd7, 3'b010, 5'd9));
        place(rType(7'h00, 5'd7, 5'd8, 3'b011, 5'd10));
        place(rType(7'h00, 5'd7, 5'd9, 3'b111, 5'd11));
        place(iType(12'd5, 5'd10, 3'b000, 5'd12));
        place(haltWord);
        runProgram("bypassChains");
    endtask

    task automatic zeroRegister();
        clearMemory();
        place(iType(12'd55, 5'd0, 3'b000, 5'd0));
        place(uType(20'h12345, 5'd0));
        place(iType(12'd1, 5'd0, 3'b000, 5'd1));
        place(rType(7'h00, 5'd0, 5'd0, 3'b000, 5'd2));
        place(iType(12'd7, 5'd1, 3'b000, 5'd0));
        place(rType(7'h00, 5'd1, 5'd0, 3'b000, 5'd3));
        place(rType(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        place(rType(7'h00, 5'd2, 5'd0, 3'b110, 5'd4));
        place(haltWord);
        runProgram("zeroRegister");
    endtask

    // halt in slot B, younger words behind it
    task automatic haltDrain();
        clearMemory();
        place(iType(12'd1, 5'd0, 3'b000, 5'd1));
        place(iType(12'd2, 5'd0, 3'b000, 5'd2));
        place(iType(12'd3, 5'd0, 3'b000, 5'd3));
        place(haltWord);
        place(iType(12'd4, 5'd0, 3'b000, 5'd4));
        place(iType(12'd5, 5'd0, 3'b000, 5'd5));
        place(uType(20'h00abc, 5'd6));
        runProgram("haltDrain");
    endtask

    task automatic randomProgram();
        logic [31:0] r;
        logic [31:0] v;
        logic [2:0] f3;
        logic alt;
        clearMemory();
        for (int n = 0; n < 60; n++) begin
            r = nextRandom();
            v = nextRandom();
            f3 = r[27:25];
            alt = r[28] && (f3 == 3'b000 || f3 == 3'b101);
            // registers x0..x7 only, so dependences are dense
            case (r[30:29])
                2'd0:    place(uType(v[31:12], {2'b00, r[18:16]}));
                2'd1:    place(rType(alt ? 7'h20 : 7'h00, {2'b00, r[24:22]}, {2'b00, r[21:19]},
                                     f3, {2'b00, r[18:16]}));
                default: begin
                    if (f3 == 3'b001 || f3 == 3'b101)
                        place(iType({1'b0, alt, 5'd0, v[31:27]}, {2'b00, r[21:19]}, f3,
                                    {2'b00, r[18:16]}));
                    else
                        place(iType(v[31:20], {2'b00, r[21:19]}, f3, {2'b00, r[18:16]}));
                end
            endcase
        end
        place(haltWord);
        runProgram("randomProgram");
    endtask

    initial begin
        reset = 1'b1;
        errorCount = 0;
        checkCount = 0;
        lcgState = 32'h41a2_7caa;
        clearMemory();
        independentPairs();
        splitPackets();
        bypassChains();
        zeroRegister();
        haltDrain();
        randomProgram();
        errorCount += dualIssueCore_inst.props.assertFailures;
        $display("checks run %0d, errors %0d, assertion failures %0d", checkCount, errorCount,
                 dualIssueCore_inst.props.assertFailures);
        if (errorCount == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- tb.f
hw/rvIsaPkg.sv
hw/coreCfgPkg.sv
hw/fetchUnit.sv
hw/decodeUnit.sv
hw/regFile.sv
hw/alu.sv
hw/bypassUnit.sv
hw/dualIssueCore.sv
sim/dualIssueCore_properties.sv
sim/dualIssueTb.sv
